//--- compile.f
+incdir+sim
logic/exec_types_pkg.sv
logic/alu_op_pkg.sv
logic/alu_ctrl_if.sv
logic/operand_forward.sv
logic/op_decode.sv
logic/int_alu.sv
logic/shift_unit.sv
logic/exec_lane.sv
logic/exec_cluster.sv
sim/tb_exec_cluster.sv

//--- logic/alu_ctrl_if.sv
interface alu_ctrl_if;

  logic       valid;
  logic       unit_shift;    // shifter result, else alu.
  logic [1:0] logic_fn;
  logic       sub;           // invert b.
  logic [1:0] cin_sel;
  logic       narrow;
  logic       shift_right;
  logic       shift_arith;
  logic       writes_result; // low for compare.

  modport dec (
    output valid, unit_shift, logic_fn, sub, cin_sel, narrow,
           shift_right, shift_arith, writes_result
  );

  modport unit (
    input valid, unit_shift, logic_fn, sub, cin_sel, narrow,
          shift_right, shift_arith, writes_result
  );

  modport lane (input valid, unit_shift, writes_result);

endinterface

//--- logic/alu_op_pkg.sv
package alu_op_pkg;

  localparam int op_w   = 12;
  localparam int code_w = 8;

  // plain opcodes, low byte of the op word.
  localparam logic [code_w-1:0] op_add = 8'h01;
  localparam logic [code_w-1:0] op_sub = 8'h02;
  localparam logic [code_w-1:0] op_cmp = 8'h03;
  localparam logic [code_w-1:0] op_and = 8'h04;
  localparam logic [code_w-1:0] op_or  = 8'h05;
  localparam logic [code_w-1:0] op_xor = 8'h06;
  localparam logic [code_w-1:0] op_shl = 8'h07;
  localparam logic [code_w-1:0] op_shr = 8'h08;
  localparam logic [code_w-1:0] op_sar = 8'h09;

  // codes 60 and 61 belong to the carry family.
  localparam logic [code_w-2:0] carry_family = 7'd30;

  // carry-in sources.
  localparam logic [1:0] cin_zero  = 2'd0;
  localparam logic [1:0] cin_one   = 2'd1;
  localparam logic [1:0] cin_flag  = 2'd2;
  localparam logic [1:0] cin_nflag = 2'd3;

  // logic unit functions, none means arithmetic.
  localparam logic [1:0] fn_none = 2'd0;
  localparam logic [1:0] fn_and  = 2'd1;
  localparam logic [1:0] fn_or   = 2'd2;
  localparam logic [1:0] fn_xor  = 2'd3;

  typedef union packed {
    struct packed {
      logic [op_w-code_w-1:0] modifier; // bit 0 is narrow.
      logic [code_w-1:0]      code;
    } plain;
    struct packed {
      logic [1:0]        cin_sel;
      logic              narrow;
      logic              spare;
      logic [code_w-2:0] family;
      logic              polarity; // 1 is subtract.
    } carry;
  } op_word_u;

endpackage

//--- logic/exec_cluster.sv
module exec_cluster #(
  parameter int num_lanes = 2
) (
  input  logic                                             clk,
  input  logic                                             arst_n,
  input  logic [num_lanes-1:0]                             issue_valid,
  input  logic [num_lanes-1:0][alu_op_pkg::op_w-1:0]       op,
  input  logic [num_lanes-1:0][exec_types_pkg::data_w-1:0] a,
  input  logic [num_lanes-1:0][exec_types_pkg::data_w-1:0] b,
  input  logic [num_lanes-1:0][exec_types_pkg::flag_w-1:0] s,
  input  logic [num_lanes-1:0][num_lanes-1:0]              fwd_a_new,
  input  logic [num_lanes-1:0][num_lanes-1:0]              fwd_a_old,
  input  logic [num_lanes-1:0][num_lanes-1:0]              fwd_b_new,
  input  logic [num_lanes-1:0][num_lanes-1:0]              fwd_b_old,
  input  logic [num_lanes-1:0][num_lanes-1:0]              fwd_s_new,
  input  logic [num_lanes-1:0][num_lanes-1:0]              fwd_s_old,
  output logic [num_lanes-1:0]                             res_valid,
  output logic [num_lanes-1:0]                             res_wr,
  output logic [num_lanes-1:0][exec_types_pkg::data_w-1:0] res_data,
  output logic [num_lanes-1:0][exec_types_pkg::flag_w-1:0] res_flags
);
  import exec_types_pkg::*;

  // result buses, every lane reads all of them.
  logic [num_lanes-1:0][data_w-1:0] bus_data_new;
  logic [num_lanes-1:0][data_w-1:0] bus_data_old;
  logic [num_lanes-1:0][flag_w-1:0] bus_flag_new;
  logic [num_lanes-1:0][flag_w-1:0] bus_flag_old;

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    exec_lane #(.num_lanes(num_lanes)) lane_i (
      .clk           (clk),
      .arst_n        (arst_n),
      .issue_valid   (issue_valid[i]),
      .op            (op[i]),
      .a             (a[i]),
      .b             (b[i]),
      .s             (s[i]),
      .fwd_a_new     (fwd_a_new[i]),
      .fwd_a_old     (fwd_a_old[i]),
      .fwd_b_new     (fwd_b_new[i]),
      .fwd_b_old     (fwd_b_old[i]),
      .fwd_s_new     (fwd_s_new[i]),
      .fwd_s_old     (fwd_s_old[i]),
      .bus_data_new  (bus_data_new),
      .bus_data_old  (bus_data_old),
      .bus_flag_new  (bus_flag_new),
      .bus_flag_old  (bus_flag_old),
      .res_valid     (res_valid[i]),
      .res_wr        (res_wr[i]),
      .res_data      (bus_data_new[i]),
      .res_flags     (bus_flag_new[i]),
      .res_data_old  (bus_data_old[i]),
      .res_flags_old (bus_flag_old[i])
    );
  end

  assign res_data  = bus_data_new; // current buses are the lane results.
  assign res_flags = bus_flag_new;

endmodule

//--- logic/exec_lane.sv
module exec_lane #(
  parameter int num_lanes = 2
) (
  input  logic                                                clk,
  input  logic                                                arst_n,
  input  logic                                                issue_valid,
  input  alu_op_pkg::op_word_u                                op,
  input  logic [exec_types_pkg::data_w-1:0]                   a,
  input  logic [exec_types_pkg::data_w-1:0]                   b,
  input  logic [exec_types_pkg::flag_w-1:0]                   s,
  input  logic [num_lanes-1:0]                                fwd_a_new,
  input  logic [num_lanes-1:0]                                fwd_a_old,
  input  logic [num_lanes-1:0]                                fwd_b_new,
  input  logic [num_lanes-1:0]                                fwd_b_old,
  input  logic [num_lanes-1:0]                                fwd_s_new,
  input  logic [num_lanes-1:0]                                fwd_s_old,
  input  logic [num_lanes-1:0][exec_types_pkg::data_w-1:0]    bus_data_new,
  input  logic [num_lanes-1:0][exec_types_pkg::data_w-1:0]    bus_data_old,
  input  logic [num_lanes-1:0][exec_types_pkg::flag_w-1:0]    bus_flag_new,
  input  logic [num_lanes-1:0][exec_types_pkg::flag_w-1:0]    bus_flag_old,
  output logic                                                res_valid,
  output logic                                                res_wr,
  output logic [exec_types_pkg::data_w-1:0]                   res_data,
  output logic [exec_types_pkg::flag_w-1:0]                   res_flags,
  output logic [exec_types_pkg::data_w-1:0]                   res_data_old,
  output logic [exec_types_pkg::flag_w-1:0]                   res_flags_old
);
  import exec_types_pkg::*;

  alu_ctrl_if ctrl ();

  logic [data_w-1:0] a_q;
  logic [data_w-1:0] b_q;
  logic [flag_w-1:0] s_q;
  logic [data_w-1:0] alu_res;
  logic [flag_w-1:0] alu_flags;
  logic [data_w-1:0] sh_res;
  logic [flag_w-1:0] sh_flags;

  operand_forward #(.width(data_w), .num_lanes(num_lanes)) fwd_a_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .port_val (a),
    .sel_new  (fwd_a_new),
    .sel_old  (fwd_a_old),
    .bus_new  (bus_data_new),
    .bus_old  (bus_data_old),
    .operand  (a_q)
  );

  operand_forward #(.width(data_w), .num_lanes(num_lanes)) fwd_b_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .port_val (b),
    .sel_new  (fwd_b_new),
    .sel_old  (fwd_b_old),
    .bus_new  (bus_data_new),
    .bus_old  (bus_data_old),
    .operand  (b_q)
  );

  // flag operand forwards from the flag buses.
  operand_forward #(.width(flag_w), .num_lanes(num_lanes)) fwd_s_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .port_val (s),
    .sel_new  (fwd_s_new),
    .sel_old  (fwd_s_old),
    .bus_new  (bus_flag_new),
    .bus_old  (bus_flag_old),
    .operand  (s_q)
  );

  op_decode dec_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .op          (op),
    .ctrl        (ctrl.dec)
  );

  int_alu alu_i (
    .a      (a_q),
    .b      (b_q),
    .s      (s_q),
    .ctrl   (ctrl.unit),
    .result (alu_res),
    .flags  (alu_flags)
  );

  shift_unit shift_i (
    .a      (a_q),
    .b      (b_q),
    .ctrl   (ctrl.unit),
    .result (sh_res),
    .flags  (sh_flags)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid     <= 1'b0;
      res_wr        <= 1'b0;
      res_data      <= '0;
      res_flags     <= '0;
      res_data_old  <= '0;
      res_flags_old <= '0;
    end else begin
      res_valid <= ctrl.valid;
      res_wr    <= ctrl.valid & ctrl.writes_result;
      if (ctrl.valid) begin
        res_data  <= ctrl.unit_shift ? sh_res : alu_res;
        res_flags <= ctrl.unit_shift ? sh_flags : alu_flags;
      end
      // one cycle older copy for the old buses.
      res_data_old  <= res_data;
      res_flags_old <= res_flags;
    end
  end

endmodule

//--- logic/exec_types_pkg.sv
package exec_types_pkg;

  // datapath widths.
  localparam int data_w   = 64;
  localparam int narrow_w = 32; // narrow forms work on the low half.
  localparam int flag_w   = 4;

  // flag bit positions.
  localparam int flag_c = 0;
  localparam int flag_z = 1;
  localparam int flag_n = 2;
  localparam int flag_v = 3;

  // shift amount, enough for 0 to 63.
  localparam int shamt_w = 6;

endpackage

//--- logic/int_alu.sv
module int_alu (
  input  logic [exec_types_pkg::data_w-1:0] a,
  input  logic [exec_types_pkg::data_w-1:0] b,
  input  logic [exec_types_pkg::flag_w-1:0] s,
  alu_ctrl_if.unit                          ctrl,
  output logic [exec_types_pkg::data_w-1:0] result,
  output logic [exec_types_pkg::flag_w-1:0] flags
);
  import exec_types_pkg::*;
  import alu_op_pkg::*;

  logic [data_w-1:0] b_eff;
  logic              cin;
  logic [data_w:0]   sum_w;
  logic [narrow_w:0] sum_n;
  logic [data_w-1:0] logic_res;
  logic              carry;
  logic              top_a;
  logic              top_b;
  logic              top_r;

  assign b_eff = ctrl.sub ? ~b : b;

  always_comb begin
    case (ctrl.cin_sel)
      cin_zero: cin = 1'b0;
      cin_one:  cin = 1'b1;
      cin_flag: cin = s[flag_c];
      default:  cin = ~s[flag_c];
    endcase
  end

  assign sum_w = {1'b0, a} + {1'b0, b_eff} + {{data_w{1'b0}}, cin};
  assign sum_n = {1'b0, a[narrow_w-1:0]} + {1'b0, b_eff[narrow_w-1:0]}
               + {{narrow_w{1'b0}}, cin};

  always_comb begin
    case (ctrl.logic_fn)
      fn_and:  logic_res = a & b;
      fn_or:   logic_res = a | b;
      fn_xor:  logic_res = a ^ b;
      default: logic_res = '0;
    endcase
  end

  always_comb begin
    if (ctrl.logic_fn != fn_none) begin
      result = ctrl.narrow ? {{(data_w-narrow_w){1'b0}}, logic_res[narrow_w-1:0]}
                           : logic_res;
      carry  = 1'b0;
    end else if (ctrl.narrow) begin
      result = {{(data_w-narrow_w){1'b0}}, sum_n[narrow_w-1:0]};
      carry  = sum_n[narrow_w];
    end else begin
      result = sum_w[data_w-1:0];
      carry  = sum_w[data_w]; // set means no borrow on subtract.
    end
  end

  // sign bits at 31 or 63.
  assign top_a = ctrl.narrow ? a[narrow_w-1] : a[data_w-1];
  assign top_b = ctrl.narrow ? b_eff[narrow_w-1] : b_eff[data_w-1];
  assign top_r = ctrl.narrow ? result[narrow_w-1] : result[data_w-1];

  always_comb begin
    flags         = '0;
    flags[flag_c] = carry;
    flags[flag_z] = (result == '0);
    flags[flag_n] = top_r;
    flags[flag_v] = (ctrl.logic_fn == fn_none) && (top_a == top_b) && (top_r != top_a);
  end

endmodule

//--- logic/op_decode.sv
module op_decode (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                issue_valid,
  input  alu_op_pkg::op_word_u op,
  alu_ctrl_if.dec             ctrl
);
  import alu_op_pkg::*;

  op_word_u op_q;
  logic     valid_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      op_q    <= '0;
    end else begin
      valid_q <= issue_valid;
      op_q    <= op;
    end
  end

  always_comb begin
    ctrl.valid         = valid_q;
    ctrl.unit_shift    = 1'b0;
    ctrl.logic_fn      = fn_none;
    ctrl.sub           = 1'b0;
    ctrl.cin_sel       = cin_zero;
    ctrl.narrow        = op_q.plain.modifier[0];
    ctrl.shift_right   = 1'b0;
    ctrl.shift_arith   = 1'b0;
    ctrl.writes_result = 1'b1;

    if (op_q.carry.family == carry_family) begin
      // same word, read as the carry view.
      ctrl.sub     = op_q.carry.polarity;
      ctrl.cin_sel = op_q.carry.cin_sel;
      ctrl.narrow  = op_q.carry.narrow;
    end else begin
      case (op_q.plain.code)
        op_add: ctrl.cin_sel = cin_zero;
        op_sub: begin
          ctrl.sub     = 1'b1;
          ctrl.cin_sel = cin_one;
        end
        op_cmp: begin
          ctrl.sub           = 1'b1;
          ctrl.cin_sel       = cin_one;
          ctrl.writes_result = 1'b0; // flags only.
        end
        op_and: ctrl.logic_fn = fn_and;
        op_or:  ctrl.logic_fn = fn_or;
        op_xor: ctrl.logic_fn = fn_xor;
        op_shl: ctrl.unit_shift = 1'b1;
        op_shr: begin
          ctrl.unit_shift  = 1'b1;
          ctrl.shift_right = 1'b1;
        end
        op_sar: begin
          ctrl.unit_shift  = 1'b1;
          ctrl.shift_right = 1'b1;
          ctrl.shift_arith = 1'b1;
        end
        default: begin
          // unknown code runs as and, nothing written back.
          ctrl.logic_fn      = fn_and;
          ctrl.writes_result = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- logic/operand_forward.sv
module operand_forward #(
  parameter int width     = exec_types_pkg::data_w,
  parameter int num_lanes = 2
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic [width-1:0]                port_val,
  input  logic [num_lanes-1:0]            sel_new,
  input  logic [num_lanes-1:0]            sel_old,
  input  logic [num_lanes-1:0][width-1:0] bus_new,
  input  logic [num_lanes-1:0][width-1:0] bus_old,
  output logic [width-1:0]                operand
);

  logic [width-1:0] pick;

  // selects are one-hot, so an or of the picked buses is enough.
  always_comb begin
    pick = port_val;
    if (|sel_new) begin
      pick = '0;
      for (int i = 0; i < num_lanes; i++) begin
        if (sel_new[i]) pick = pick | bus_new[i];
      end
    end else if (|sel_old) begin
      pick = '0;
      for (int i = 0; i < num_lanes; i++) begin
        if (sel_old[i]) pick = pick | bus_old[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      operand <= '0;
    end else begin
      operand <= pick;
    end
  end

endmodule

//--- logic/shift_unit.sv
module shift_unit (
  input  logic [exec_types_pkg::data_w-1:0] a,
  input  logic [exec_types_pkg::data_w-1:0] b,
  alu_ctrl_if.unit                          ctrl,
  output logic [exec_types_pkg::data_w-1:0] result,
  output logic [exec_types_pkg::flag_w-1:0] flags
);
  import exec_types_pkg::*;

  logic [shamt_w-1:0]  amt;
  logic [data_w-1:0]   wide_res;
  logic [narrow_w-1:0] narrow_res;

  assign amt = b[shamt_w-1:0];

  always_comb begin
    if (!ctrl.shift_right) begin
      wide_res = a << amt;
    end else if (ctrl.shift_arith) begin
      wide_res = $unsigned($signed(a) >>> amt);
    end else begin
      wide_res = a >> amt;
    end
  end

  // narrow forms use five amount bits and fill from bit 31.
  always_comb begin
    if (!ctrl.shift_right) begin
      narrow_res = a[narrow_w-1:0] << amt[shamt_w-2:0];
    end else if (ctrl.shift_arith) begin
      narrow_res = $unsigned($signed(a[narrow_w-1:0]) >>> amt[shamt_w-2:0]);
    end else begin
      narrow_res = a[narrow_w-1:0] >> amt[shamt_w-2:0];
    end
  end

  assign result = ctrl.narrow ? {{(data_w-narrow_w){1'b0}}, narrow_res} : wide_res;

  always_comb begin
    flags         = '0; // c and v stay clear.
    flags[flag_z] = (result == '0);
    flags[flag_n] = ctrl.narrow ? result[narrow_w-1] : result[data_w-1];
  end

endmodule

//--- sim/tb_vectors.svh
// each row holds lane, with_prev (issued with the row above), rnd, op, a, b, s,
// fwd {a_new, a_old, b_new, b_old, s_new, s_old}, chk, wr, data and flags.
vec_t vectors [$] = '{
  // wide add and sub.
  '{0, 0, 0, 12'h001, 64'h5, 64'h3, 4'h0, 12'h000, 1, 1, 64'h8, 4'h0},
  '{1, 0, 0, 12'h001, 64'hffffffffffffffff, 64'h1, 4'h0, 12'h000, 1, 1, 64'h0, 4'h3},
  '{0, 0, 0, 12'h001, 64'h7fffffffffffffff, 64'h1, 4'h0, 12'h000, 1, 1,
    64'h8000000000000000, 4'hc},
  '{0, 0, 0, 12'h002, 64'h5, 64'h5, 4'h0, 12'h000, 1, 1, 64'h0, 4'h3},
  '{1, 0, 0, 12'h002, 64'h3, 64'h5, 4'h0, 12'h000, 1, 1, 64'hfffffffffffffffe, 4'h4},
  '{0, 0, 0, 12'h002, 64'h8000000000000000, 64'h1, 4'h0, 12'h000, 1, 1,
    64'h7fffffffffffffff, 4'h9},
  // narrow add and sub ignore the upper half.
  '{0, 0, 0, 12'h101, 64'h12345678ffffffff, 64'h1, 4'h0, 12'h000, 1, 1, 64'h0, 4'h3},
  '{1, 0, 0, 12'h101, 64'h7fffffff, 64'h1, 4'h0, 12'h000, 1, 1, 64'h80000000, 4'hc},
  '{0, 0, 0, 12'h102, 64'h0, 64'h1, 4'h0, 12'h000, 1, 1, 64'hffffffff, 4'h4},
  // compare and logic.
  '{0, 0, 0, 12'h003, 64'h5, 64'h5, 4'h0, 12'h000, 1, 0, 64'h0, 4'h3},
  '{0, 0, 0, 12'h004, 64'h80000000000000ff, 64'h8000000000000f0f, 4'hf, 12'h000, 1, 1,
    64'h800000000000000f, 4'h4},
  '{1, 0, 0, 12'h005, 64'h0, 64'h0, 4'hf, 12'h000, 1, 1, 64'h0, 4'h2},
  '{0, 0, 0, 12'h006, 64'hffffffffffffffff, 64'hffffffffffffffff, 4'h0, 12'h000, 1, 1,
    64'h0, 4'h2},
  '{0, 0, 0, 12'h106, 64'hffffffff00000000, 64'h80000000, 4'h0, 12'h000, 1, 1,
    64'h80000000, 4'h4},
  '{1, 0, 0, 12'h0ff, 64'hff, 64'h0f, 4'h0, 12'h000, 1, 0, 64'h0f, 4'h0},
  // shifts.
  '{0, 0, 0, 12'h007, 64'h8000000000000001, 64'd0, 4'h0, 12'h000, 1, 1,
    64'h8000000000000001, 4'h4},
  '{0, 0, 0, 12'h007, 64'h8000000000000001, 64'd1, 4'h0, 12'h000, 1, 1, 64'h2, 4'h0},
  '{1, 0, 0, 12'h007, 64'h8000000000000001, 64'd31, 4'h0, 12'h000, 1, 1, 64'h80000000, 4'h0},
  '{0, 0, 0, 12'h007, 64'h8000000000000001, 64'd32, 4'h0, 12'h000, 1, 1, 64'h100000000, 4'h0},
  '{0, 0, 0, 12'h007, 64'h8000000000000001, 64'd63, 4'h0, 12'h000, 1, 1,
    64'h8000000000000000, 4'h4},
  '{1, 0, 0, 12'h008, 64'h8000000000000001, 64'd0, 4'h0, 12'h000, 1, 1,
    64'h8000000000000001, 4'h4},
  '{0, 0, 0, 12'h008, 64'h8000000000000001, 64'd1, 4'h0, 12'h000, 1, 1,
    64'h4000000000000000, 4'h0},
  '{0, 0, 0, 12'h008, 64'h8000000000000001, 64'd31, 4'h0, 12'h000, 1, 1, 64'h100000000, 4'h0},
  '{1, 0, 0, 12'h008, 64'h8000000000000001, 64'd32, 4'h0, 12'h000, 1, 1, 64'h80000000, 4'h0},
  '{0, 0, 0, 12'h008, 64'h8000000000000001, 64'd63, 4'h0, 12'h000, 1, 1, 64'h1, 4'h0},
  '{0, 0, 0, 12'h009, 64'h8000000000000001, 64'd0, 4'h0, 12'h000, 1, 1,
    64'h8000000000000001, 4'h4},
  '{0, 0, 0, 12'h009, 64'h8000000000000001, 64'd1, 4'h0, 12'h000, 1, 1,
    64'hc000000000000000, 4'h4},
  '{1, 0, 0, 12'h009, 64'h8000000000000001, 64'd31, 4'h0, 12'h000, 1, 1,
    64'hffffffff00000000, 4'h4},
  '{1, 0, 0, 12'h009, 64'h8000000000000001, 64'd32, 4'h0, 12'h000, 1, 1,
    64'hffffffff80000000, 4'h4},
  '{0, 0, 0, 12'h009, 64'h8000000000000001, 64'd63, 4'h0, 12'h000, 1, 1,
    64'hffffffffffffffff, 4'h4},
  '{0, 0, 0, 12'h109, 64'h80000000, 64'd4, 4'h0, 12'h000, 1, 1, 64'hf8000000, 4'h4},
  '{0, 0, 0, 12'h108, 64'h80000000, 64'd31, 4'h0, 12'h000, 1, 1, 64'h1, 4'h0},
  '{1, 0, 0, 12'h107, 64'h1, 64'd32, 4'h0, 12'h000, 1, 1, 64'h1, 4'h0},
  // carry family on a = 5 and b = 3.
  '{0, 0, 0, 12'h03c, 64'h5, 64'h3, 4'h1, 12'h000, 1, 1, 64'h8, 4'h0},
  '{1, 0, 0, 12'h03c, 64'h5, 64'h3, 4'h0, 12'h000, 1, 1, 64'h8, 4'h0},
  '{0, 0, 0, 12'h43c, 64'h5, 64'h3, 4'h0, 12'h000, 1, 1, 64'h9, 4'h0},
  '{0, 0, 0, 12'h43c, 64'h5, 64'h3, 4'h1, 12'h000, 1, 1, 64'h9, 4'h0},
  '{1, 0, 0, 12'h83c, 64'h5, 64'h3, 4'h0, 12'h000, 1, 1, 64'h8, 4'h0},
  '{0, 0, 0, 12'h83c, 64'h5, 64'h3, 4'h1, 12'h000, 1, 1, 64'h9, 4'h0},
  '{0, 0, 0, 12'hc3c, 64'h5, 64'h3, 4'h0, 12'h000, 1, 1, 64'h9, 4'h0},
  '{1, 0, 0, 12'hc3c, 64'h5, 64'h3, 4'h1, 12'h000, 1, 1, 64'h8, 4'h0},
  '{0, 0, 0, 12'h03d, 64'h5, 64'h3, 4'h1, 12'h000, 1, 1, 64'h1, 4'h1},
  '{1, 0, 0, 12'h03d, 64'h5, 64'h3, 4'h0, 12'h000, 1, 1, 64'h1, 4'h1},
  '{0, 0, 0, 12'h43d, 64'h5, 64'h3, 4'h0, 12'h000, 1, 1, 64'h2, 4'h1},
  '{0, 0, 0, 12'h43d, 64'h5, 64'h3, 4'h1, 12'h000, 1, 1, 64'h2, 4'h1},
  '{0, 0, 0, 12'h83d, 64'h5, 64'h3, 4'h0, 12'h000, 1, 1, 64'h1, 4'h1},
  '{1, 0, 0, 12'h83d, 64'h5, 64'h3, 4'h1, 12'h000, 1, 1, 64'h2, 4'h1},
  '{0, 0, 0, 12'hc3d, 64'h5, 64'h3, 4'h0, 12'h000, 1, 1, 64'h2, 4'h1},
  '{0, 0, 0, 12'hc3d, 64'h5, 64'h3, 4'h1, 12'h000, 1, 1, 64'h1, 4'h1},
  '{0, 0, 0, 12'h23c, 64'hffffffff, 64'h0, 4'h0, 12'h000, 1, 1, 64'hffffffff, 4'h4},
  '{1, 0, 0, 12'h63c, 64'hffffffff, 64'h0, 4'h0, 12'h000, 1, 1, 64'h0, 4'h3},
  // forwarding with both lanes issuing each cycle.
  '{0, 0, 0, 12'h001, 64'd10, 64'd20, 4'h0, 12'h000, 0, 0, 64'h0, 4'h0},
  '{1, 1, 0, 12'h002, 64'd100, 64'd1, 4'h0, 12'h000, 0, 0, 64'h0, 4'h0},
  '{0, 0, 0, 12'h001, 64'd1, 64'd1, 4'h0, 12'h000, 0, 0, 64'h0, 4'h0},
  '{1, 1, 0, 12'h002, 64'd2, 64'd7, 4'h0, 12'h000, 0, 0, 64'h0, 4'h0},
  '{0, 0, 0, 12'h001, 64'd0, 64'd0, 4'h0, 12'h480, 0, 0, 64'h0, 4'h0},
  '{1, 1, 0, 12'h83c, 64'd0, 64'd5, 4'h0, 12'h808, 0, 0, 64'h0, 4'h0},
  '{0, 0, 0, 12'h006, 64'd0, 64'd0, 4'h0, 12'h100, 0, 0, 64'h0, 4'h0},
  '{1, 1, 0, 12'h001, 64'd0, 64'd0, 4'h0, 12'h240, 0, 0, 64'h0, 4'h0},
  '{0, 0, 0, 12'h83c, 64'd7, 64'd0, 4'h0, 12'h904, 0, 0, 64'h0, 4'h0},
  '{1, 1, 0, 12'hc3d, 64'd9, 64'd0, 4'h0, 12'h099, 0, 0, 64'h0, 4'h0},
  '{1, 0, 0, 12'ha3c, 64'd0, 64'd0, 4'h0, 12'h222, 0, 0, 64'h0, 4'h0},
  // random operands.
  '{0, 0, 1, 12'h001, 64'h0, 64'h0, 4'h0, 12'h000, 0, 0, 64'h0, 4'h0},
  '{1, 1, 1, 12'h83d, 64'h0, 64'h0, 4'h0, 12'h000, 0, 0, 64'h0, 4'h0},
  '{0, 0, 1, 12'h009, 64'h0, 64'h0, 4'h0, 12'h000, 0, 0, 64'h0, 4'h0},
  '{1, 1, 1, 12'h102, 64'h0, 64'h0, 4'h0, 12'h000, 0, 0, 64'h0, 4'h0},
  '{0, 0, 1, 12'hc3c, 64'h0, 64'h0, 4'h0, 12'h848, 0, 0, 64'h0, 4'h0},
  '{1, 1, 1, 12'h107, 64'h0, 64'h0, 4'h0, 12'h120, 0, 0, 64'h0, 4'h0}
};

//--- sim/tb_exec_cluster.sv
module tb_exec_cluster;
  import exec_types_pkg::*;
  import alu_op_pkg::*;

  typedef struct {
    int               lane;
    bit               with_prev;
    bit               rnd;
    logic [op_w-1:0]  op;
    logic [63:0]      a;
    logic [63:0]      b;
    logic [3:0]       s;
    logic [11:0]      fwd;
    bit               chk;
    logic             wr;
    logic [63:0]      data;
    logic [3:0]       flags;
  } vec_t;

  typedef struct {
    bit          valid;
    int          row;
    logic        wr;
    logic [63:0] data;
    logic [3:0]  flags;
    bit          chk;
    logic        twr;
    logic [63:0] tdata;
    logic [3:0]  tflags;
  } slot_t;

  `include "tb_vectors.svh"

  logic                         clk;
  logic                         arst_n;
  logic [1:0]                   issue_valid;
  logic [1:0][op_w-1:0]         op;
  logic [1:0][data_w-1:0]       a;
  logic [1:0][data_w-1:0]       b;
  logic [1:0][flag_w-1:0]       s;
  logic [1:0][1:0]              fwd_a_new, fwd_a_old, fwd_b_new;
  logic [1:0][1:0]              fwd_b_old, fwd_s_new, fwd_s_old;
  logic [1:0]                   res_valid;
  logic [1:0]                   res_wr;
  logic [1:0][data_w-1:0]       res_data;
  logic [1:0][flag_w-1:0]       res_flags;

  slot_t       pipe0 [2];
  slot_t       pipe1 [2];
  logic [63:0] bus_cur [2];
  logic [63:0] bus_old [2];
  logic [3:0]  flg_cur [2];
  logic [3:0]  flg_old [2];
  int          errors;
  int          checks;
  int          rows_done;
  bit          timed_out;

  exec_cluster #(.num_lanes(2)) dut_i (.*);

  always #2 clk = ~clk;

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // reference model built from the opcode rules.
  function automatic void model_op(input logic [11:0] w, input logic [63:0] x,
                                   input logic [63:0] y, input logic [3:0] f_in,
                                   output logic wr, output logic [63:0] r,
                                   output logic [3:0] f);
    logic        nar, sub, shift, cin, c, v, ta, tb, tr;
    logic [1:0]  csel, lfn;
    logic [64:0] sum;
    logic [63:0] yy;
    logic [31:0] r32;
    logic signed [63:0] sx;
    logic signed [31:0] sx32;
    int          amt;
    wr = 1'b1;
    nar = w[8];
    sub = 1'b0;
    shift = 1'b0;
    csel = 2'd0;
    lfn = 2'd0;
    c = 1'b0;
    v = 1'b0;
    if (w[7:1] == 7'd30) begin
      sub = w[0];
      csel = w[11:10];
      nar = w[9];
    end else begin
      case (w[7:0])
        op_add: csel = 2'd0;
        op_sub: begin
          sub = 1'b1;
          csel = 2'd1;
        end
        op_cmp: begin
          sub = 1'b1;
          csel = 2'd1;
          wr = 1'b0;
        end
        op_and: lfn = 2'd1;
        op_or:  lfn = 2'd2;
        op_xor: lfn = 2'd3;
        op_shl, op_shr, op_sar: shift = 1'b1;
        default: begin
          lfn = 2'd1;
          wr = 1'b0;
        end
      endcase
    end
    if (shift) begin
      amt = nar ? int'(y[4:0]) : int'(y[5:0]);
      sx = x;
      sx32 = x[31:0];
      if (w[7:0] == op_shl) begin
        r = x << amt;
        r32 = x[31:0] << amt;
      end else if (w[7:0] == op_shr) begin
        r = x >> amt;
        r32 = x[31:0] >> amt;
      end else begin
        r = sx >>> amt;
        r32 = sx32 >>> amt;
      end
      if (nar) r = {32'h0, r32};
    end else if (lfn != 2'd0) begin
      r = (lfn == 2'd1) ? (x & y) : (lfn == 2'd2) ? (x | y) : (x ^ y);
      if (nar) r[63:32] = '0;
    end else begin
      cin = (csel == 2'd0) ? 1'b0 : (csel == 2'd1) ? 1'b1 : (csel == 2'd2) ? f_in[0] : ~f_in[0];
      yy = sub ? ~y : y;
      if (nar) begin
        sum = {33'h0, x[31:0]} + {33'h0, yy[31:0]} + {64'h0, cin};
        c = sum[32];
        r = {32'h0, sum[31:0]};
        ta = x[31];
        tb = yy[31];
      end else begin
        sum = {1'b0, x} + {1'b0, yy} + {64'h0, cin};
        c = sum[64];
        r = sum[63:0];
        ta = x[63];
        tb = yy[63];
      end
      tr = nar ? r[31] : r[63];
      v = (ta == tb) && (tr != ta);
    end
    f = {v, nar ? r[31] : r[63], r == 64'h0, c};
  endfunction

  function automatic logic [63:0] pick_operand(input logic [1:0] sn, input logic [1:0] so,
                                               input logic [63:0] port,
                                               input logic [63:0] n0, input logic [63:0] n1,
                                               input logic [63:0] o0, input logic [63:0] o1);
    if (sn != 2'b00) return (sn[0] ? n0 : 64'h0) | (sn[1] ? n1 : 64'h0);
    if (so != 2'b00) return (so[0] ? o0 : 64'h0) | (so[1] ? o1 : 64'h0);
    return port;
  endfunction

  task automatic drive_idle();
    issue_valid = '0;
    op = '0;
    a = '0;
    b = '0;
    s = '0;
    fwd_a_new = '0;
    fwd_a_old = '0;
    fwd_b_new = '0;
    fwd_b_old = '0;
    fwd_s_new = '0;
    fwd_s_old = '0;
  endtask

  task automatic issue_row(input int idx);
    vec_t        v;
    int          ln;
    logic [63:0] av, bv, opa, opb, ops;
    logic [3:0]  sv, fo;
    logic [63:0] ro;
    logic        wo;
    v = vectors[idx];
    ln = v.lane;
    av = v.a;
    bv = v.b;
    sv = v.s;
    if (v.rnd) begin
      av = {$urandom(), $urandom()};
      bv = {$urandom(), $urandom()};
      sv = 4'($urandom());
    end
    issue_valid[ln] = 1'b1;
    op[ln] = v.op;
    a[ln] = av;
    b[ln] = bv;
    s[ln] = sv;
    {fwd_a_new[ln], fwd_a_old[ln], fwd_b_new[ln]} = v.fwd[11:6];
    {fwd_b_old[ln], fwd_s_new[ln], fwd_s_old[ln]} = v.fwd[5:0];
    opa = pick_operand(v.fwd[11:10], v.fwd[9:8], av, bus_cur[0], bus_cur[1],
                       bus_old[0], bus_old[1]);
    opb = pick_operand(v.fwd[7:6], v.fwd[5:4], bv, bus_cur[0], bus_cur[1],
                       bus_old[0], bus_old[1]);
    ops = pick_operand(v.fwd[3:2], v.fwd[1:0], {60'h0, sv}, {60'h0, flg_cur[0]},
                       {60'h0, flg_cur[1]}, {60'h0, flg_old[0]}, {60'h0, flg_old[1]});
    model_op(v.op, opa, opb, ops[3:0], wo, ro, fo);
    pipe0[ln] = '{1'b1, idx, wo, ro, fo, v.chk, v.wr, v.data, v.flags};
  endtask

  // moves the model pipe one cycle and checks what the dut shows now.
  task automatic advance();
    slot_t done;
    int    e0;
    for (int ln = 0; ln < 2; ln++) begin
      bus_old[ln] = bus_cur[ln];
      flg_old[ln] = flg_cur[ln];
      done = pipe1[ln];
      pipe1[ln] = pipe0[ln];
      pipe0[ln].valid = 1'b0;
      if (!done.valid) begin
        check_val($sformatf("lane %0d idle res_valid", ln), 64'(res_valid[ln]), 64'h0);
        check_val($sformatf("lane %0d idle res_wr", ln), 64'(res_wr[ln]), 64'h0);
      end else begin
        bus_cur[ln] = done.data;
        flg_cur[ln] = done.flags;
        e0 = errors;
        check_val($sformatf("row %0d res_valid", done.row), 64'(res_valid[ln]), 64'h1);
        check_val($sformatf("row %0d res_wr", done.row), 64'(res_wr[ln]), 64'(done.wr));
        check_val($sformatf("row %0d res_data", done.row), res_data[ln], done.data);
        check_val($sformatf("row %0d res_flags", done.row), 64'(res_flags[ln]),
                  64'(done.flags));
        if (done.chk) begin
          check_val($sformatf("row %0d table wr", done.row), 64'(res_wr[ln]), 64'(done.twr));
          check_val($sformatf("row %0d table data", done.row), res_data[ln], done.tdata);
          check_val($sformatf("row %0d table flags", done.row), 64'(res_flags[ln]),
                    64'(done.tflags));
        end
        rows_done++;
        $display("row %0d lane %0d op %h: %s", done.row, ln, vectors[done.row].op,
                 (errors == e0) ? "ok" : "mismatch");
      end
    end
  endtask

  initial begin
    int idx;
    int cnt;
    clk = 1'b0;
    arst_n = 1'b0;
    drive_idle();
    errors = 0;
    checks = 0;
    rows_done = 0;
    timed_out = 1'b0;
    void'($urandom(32'hd0b3));
    for (int ln = 0; ln < 2; ln++) begin
      pipe0[ln].valid = 1'b0;
      pipe1[ln].valid = 1'b0;
      bus_cur[ln] = '0;
      bus_old[ln] = '0;
      flg_cur[ln] = '0;
      flg_old[ln] = '0;
    end
    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;
    cnt = 0;
    while (res_valid !== 2'b00 && cnt < 8) begin
      @(posedge clk);
      cnt++;
    end
    if (res_valid !== 2'b00) begin
      $display("timeout: res_valid did not settle low after reset release");
      timed_out = 1'b1;
    end else begin
      idx = 0;
      while (idx < vectors.size()) begin
        @(posedge clk);
        #1;
        advance();
        drive_idle();
        issue_row(idx);
        idx++;
        while (idx < vectors.size() && vectors[idx].with_prev) begin
          issue_row(idx);
          idx++;
        end
      end
      cnt = 0;
      while ((pipe0[0].valid || pipe0[1].valid || pipe1[0].valid || pipe1[1].valid)
             && cnt < 8) begin
        @(posedge clk);
        #1;
        advance();
        drive_idle();
        cnt++;
      end
      if (pipe0[0].valid || pipe0[1].valid || pipe1[0].valid || pipe1[1].valid) begin
        $display("timeout: results still pending after the last issue");
        timed_out = 1'b1;
      end
    end
    $display("%0d rows, %0d checks, %0d errors", rows_done, checks, errors);
    if (!timed_out && errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
